// File: common/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Datapath widths fixed by the MIPS instruction format
`define NB_DATA         32
`define NB_ADDR         5
`define BANK_DEPTH      32

// Debug bus
`define WB_ADDR_W       8

// Word addresses of the debug register map
`define DBG_CTRL_ADDR   8'h00   // Bit 0 is the run flag
`define DBG_REG_BASE    8'h20   // Register window, one word per register

`endif

// File: common/decode_pkg.sv
`include "decode_cfg.svh"

package decode_pkg;

    // Register contents, extended immediates and debug bus data
    typedef logic [`NB_DATA-1:0]   reg_data_t;

    // Register number, as carried in the rs, rt and rd fields
    typedef logic [`NB_ADDR-1:0]   reg_addr_t;

    // Fetched instruction word
    typedef logic [`NB_DATA-1:0]   instr_t;

    // Opcode and funct fields are both six bits wide
    typedef logic [5:0]            opcode_t;

    // Word address on the debug bus
    typedef logic [`WB_ADDR_W-1:0] wb_addr_t;

    // Debug unit FSM
    typedef enum logic {
        DBG_IDLE = 1'b0,    // Waiting for a request
        DBG_ACK  = 1'b1     // Access done at the next edge, ack follows
    } dbg_state_e;

endpackage

// File: register_bank/registers_bank.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module registers_bank
    import decode_pkg::*;
(
    input  logic      i_clock,
    input  logic      i_reset,
    input  logic      i_enable,         // Run flag from the debug unit
    input  logic      i_reg_write,      // RegWrite from write-back
    input  reg_addr_t i_read_reg_a,
    input  reg_addr_t i_read_reg_b,
    input  reg_addr_t i_write_reg,      // Write-back target
    input  reg_data_t i_write_data,
    input  logic      i_read_enable,    // Debug read request
    input  reg_addr_t i_read_address,   // Debug read register
    output reg_data_t o_data_a,
    output reg_data_t o_data_b,
    output reg_data_t o_debug_data
);

    reg_data_t registers [`BANK_DEPTH];
    logic      write_en;

    // Writes to register 0 are dropped, so it stays zero
    assign write_en = i_enable && i_reg_write && (i_write_reg != '0);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < `BANK_DEPTH; i++) begin
                registers[i] <= '0;
            end
        end else if (write_en) begin
            registers[i_write_reg] <= i_write_data;
        end
    end

    // Read ports sample the array before this edge's write lands,
    // so a same-cycle read of the written register sees the old value
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_data_a <= '0;
            o_data_b <= '0;
        end else if (i_enable) begin
            if (i_read_reg_a == '0) begin
                o_data_a <= '0;   // r0 reads zero
            end else begin
                o_data_a <= registers[i_read_reg_a];
            end
            if (i_read_reg_b == '0) begin
                o_data_b <= '0;
            end else begin
                o_data_b <= registers[i_read_reg_b];
            end
        end
    end

    // Debug path is combinational; the debug unit latches it
    assign o_debug_data = i_read_enable ? registers[i_read_address] : '0;

endmodule

// File: logic/instruction_decoder.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module instruction_decoder
    import decode_pkg::*;
(
    input  logic      i_clock,
    input  logic      i_reset,
    input  logic      i_enable,       // Stage advances only while set
    input  instr_t    i_instruction,
    output reg_addr_t o_rs,
    output reg_addr_t o_rt,
    output reg_addr_t o_dest_reg,
    output reg_data_t o_immediate,
    output logic      o_reg_write,
    output logic      o_mem_read,
    output logic      o_mem_write,
    output logic      o_branch,
    output opcode_t   o_alu_op        // Opcode, or funct for R-type
);

    localparam opcode_t OP_RTYPE = 6'd0;
    localparam opcode_t OP_BEQ   = 6'd4;
    localparam opcode_t OP_BNE   = 6'd5;
    localparam opcode_t OP_ADDI  = 6'd8;    // First I-type arithmetic
    localparam opcode_t OP_ANDI  = 6'd12;   // First zero-extended
    localparam opcode_t OP_XORI  = 6'd14;   // Last zero-extended
    localparam opcode_t OP_LUI   = 6'd15;   // Last I-type arithmetic
    localparam opcode_t OP_LW    = 6'd35;
    localparam opcode_t OP_SW    = 6'd43;

    opcode_t     opcode;
    opcode_t     funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [15:0] imm16;
    reg_data_t   imm_sext;
    reg_data_t   imm_zext;

    reg_addr_t   dest_next;
    reg_data_t   imm_next;
    logic        reg_write_next;
    logic        mem_read_next;
    logic        mem_write_next;
    logic        branch_next;
    opcode_t     alu_op_next;

    // Field split
    assign opcode   = i_instruction[31:26];
    assign rs       = i_instruction[25:21];
    assign rt       = i_instruction[20:16];
    assign rd       = i_instruction[15:11];
    assign funct    = i_instruction[5:0];
    assign imm16    = i_instruction[15:0];
    assign imm_sext = {{(`NB_DATA-16){imm16[15]}}, imm16};
    assign imm_zext = {{(`NB_DATA-16){1'b0}}, imm16};

    always_comb begin
        dest_next      = '0;
        imm_next       = '0;
        reg_write_next = 1'b0;
        mem_read_next  = 1'b0;
        mem_write_next = 1'b0;
        branch_next    = 1'b0;
        alu_op_next    = opcode;
        case (opcode) inside
            OP_RTYPE: begin
                dest_next      = rd;
                reg_write_next = 1'b1;
                alu_op_next    = funct;
            end
            [OP_ADDI:OP_LUI]: begin
                dest_next      = rt;
                reg_write_next = 1'b1;
                // Logical immediates are zero-extended
                if (opcode inside {[OP_ANDI:OP_XORI]}) begin
                    imm_next = imm_zext;
                end else begin
                    imm_next = imm_sext;
                end
            end
            OP_LW: begin
                dest_next      = rt;
                reg_write_next = 1'b1;
                mem_read_next  = 1'b1;
                imm_next       = imm_sext;
            end
            OP_SW: begin
                mem_write_next = 1'b1;
                imm_next       = imm_sext;   // Address offset
            end
            OP_BEQ, OP_BNE: begin
                branch_next = 1'b1;
                imm_next    = imm_sext;      // Branch offset
            end
            default: begin
                // Jumps and unknown opcodes decode as a no-op
            end
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_rs        <= '0;
            o_rt        <= '0;
            o_dest_reg  <= '0;
            o_immediate <= '0;
            o_reg_write <= 1'b0;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
            o_branch    <= 1'b0;
            o_alu_op    <= '0;
        end else if (i_enable) begin
            o_rs        <= rs;
            o_rt        <= rt;
            o_dest_reg  <= dest_next;
            o_immediate <= imm_next;
            o_reg_write <= reg_write_next;
            o_mem_read  <= mem_read_next;
            o_mem_write <= mem_write_next;
            o_branch    <= branch_next;
            o_alu_op    <= alu_op_next;
        end
    end

endmodule

// File: logic/debug_unit.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module debug_unit
    import decode_pkg::*;
(
    input  logic      i_clock,
    input  logic      i_reset,
    input  logic      i_wb_cyc,
    input  logic      i_wb_stb,
    input  logic      i_wb_we,
    input  wb_addr_t  i_wb_adr,
    input  reg_data_t i_wb_dat,
    input  reg_data_t i_debug_data,     // From the bank's debug port
    output reg_data_t o_wb_dat,
    output logic      o_wb_ack,
    output logic      o_run,            // Stage enable
    output logic      o_read_enable,
    output reg_addr_t o_read_address
);

    dbg_state_e state;
    logic       request;
    logic       is_ctrl;
    logic       in_window;
    wb_addr_t   reg_offset;

    // Ack still high means the master has not dropped stb yet
    assign request = i_wb_cyc && i_wb_stb && !o_wb_ack;

    // Address decode
    assign is_ctrl    = (i_wb_adr == `DBG_CTRL_ADDR);
    assign reg_offset = i_wb_adr - `DBG_REG_BASE;    // Wraps high below the base
    assign in_window  = (reg_offset < `BANK_DEPTH);

    // Register reads are only served while the stage is halted
    assign o_read_enable  = (state == DBG_ACK) && !i_wb_we && in_window && !o_run;
    assign o_read_address = reg_offset[`NB_ADDR-1:0];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state    <= DBG_IDLE;
            o_wb_ack <= 1'b0;
            o_run    <= 1'b0;
        end else begin
            o_wb_ack <= 1'b0;   // One-cycle pulse
            case (state)
                DBG_IDLE: begin
                    if (request) begin
                        state <= DBG_ACK;
                    end
                end
                DBG_ACK: begin
                    // Master holds its signals until ack, so they are still valid here
                    if (i_wb_we && is_ctrl) begin
                        o_run <= i_wb_dat[0];
                    end
                    o_wb_ack <= 1'b1;
                    state    <= DBG_IDLE;
                end
                default: begin
                    state <= DBG_IDLE;
                end
            endcase
        end
    end

    // Read data, latched together with ack
    always_ff @(posedge i_clock) begin
        if (state == DBG_ACK) begin
            if (i_wb_we) begin
                o_wb_dat <= '0;
            end else if (is_ctrl) begin
                o_wb_dat <= {{(`NB_DATA-1){1'b0}}, o_run};
            end else if (o_read_enable) begin
                o_wb_dat <= i_debug_data;
            end else begin
                o_wb_dat <= '0;   // Unmapped, or window while running
            end
        end
    end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage
    import decode_pkg::*;
(
    input  logic      i_clock,
    input  logic      i_reset,
    input  instr_t    i_instruction,
    // Write-back port
    input  logic      i_reg_write,
    input  reg_addr_t i_write_reg,
    input  reg_data_t i_write_data,
    // Debug bus, Wishbone classic slave
    input  logic      i_wb_cyc,
    input  logic      i_wb_stb,
    input  logic      i_wb_we,
    input  wb_addr_t  i_wb_adr,
    input  reg_data_t i_wb_dat,
    output reg_data_t o_wb_dat,
    output logic      o_wb_ack,
    // Decode outputs
    output reg_addr_t o_rs,
    output reg_addr_t o_rt,
    output reg_addr_t o_dest_reg,
    output reg_data_t o_immediate,
    output logic      o_reg_write,
    output logic      o_mem_read,
    output logic      o_mem_write,
    output logic      o_branch,
    output opcode_t   o_alu_op,
    output reg_data_t o_data_a,
    output reg_data_t o_data_b
);

    logic      run;
    logic      dbg_read_enable;
    reg_addr_t dbg_read_address;
    reg_data_t dbg_data;

    instruction_decoder u_decoder (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_enable      (run),
        .i_instruction (i_instruction),
        .o_rs          (o_rs),
        .o_rt          (o_rt),
        .o_dest_reg    (o_dest_reg),
        .o_immediate   (o_immediate),
        .o_reg_write   (o_reg_write),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_branch      (o_branch),
        .o_alu_op      (o_alu_op)
    );

    // Read ports take rs and rt straight from the word so data lines up with decode
    registers_bank u_bank (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_enable       (run),
        .i_reg_write    (i_reg_write),
        .i_read_reg_a   (i_instruction[25:21]),
        .i_read_reg_b   (i_instruction[20:16]),
        .i_write_reg    (i_write_reg),
        .i_write_data   (i_write_data),
        .i_read_enable  (dbg_read_enable),
        .i_read_address (dbg_read_address),
        .o_data_a       (o_data_a),
        .o_data_b       (o_data_b),
        .o_debug_data   (dbg_data)
    );

    debug_unit u_debug (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_we        (i_wb_we),
        .i_wb_adr       (i_wb_adr),
        .i_wb_dat       (i_wb_dat),
        .i_debug_data   (dbg_data),
        .o_wb_dat       (o_wb_dat),
        .o_wb_ack       (o_wb_ack),
        .o_run          (run),
        .o_read_enable  (dbg_read_enable),
        .o_read_address (dbg_read_address)
    );

endmodule

// File: dv/decode_stage_tb.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage_tb
    import decode_pkg::*;
();

    localparam int CLOCK_PERIOD   = 100;
    localparam int RESET_CYCLES   = 10;
    localparam int WB_CYCLES      = 4;     // Drive, request, ack, release
    localparam int ACK_WAIT       = 6;
    localparam int DECODE_CYCLES  = 2;
    localparam int STALL_CYCLES   = 4;
    localparam int N_DECODE       = 9;
    localparam int PHASE_CYCLES   = RESET_CYCLES
                                  + (`BANK_DEPTH + 9) * WB_CYCLES    // Every debug access
                                  + `BANK_DEPTH + 2                  // Write-back burst
                                  + (`BANK_DEPTH / 2 + N_DECODE + 1) * DECODE_CYCLES
                                  + STALL_CYCLES + 2;
    localparam int TIMEOUT_CYCLES = 2 * PHASE_CYCLES;

    typedef struct packed {
        instr_t    instr;
        reg_addr_t dest;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      branch;
        reg_data_t imm;
        opcode_t   alu_op;
    } decode_vec_t;

    logic      i_clock;
    logic      i_reset;
    instr_t    i_instruction;
    logic      i_reg_write;
    reg_addr_t i_write_reg;
    reg_data_t i_write_data;
    logic      i_wb_cyc;
    logic      i_wb_stb;
    logic      i_wb_we;
    wb_addr_t  i_wb_adr;
    reg_data_t i_wb_dat;
    reg_data_t o_wb_dat;
    logic      o_wb_ack;
    reg_addr_t o_rs;
    reg_addr_t o_rt;
    reg_addr_t o_dest_reg;
    reg_data_t o_immediate;
    logic      o_reg_write;
    logic      o_mem_read;
    logic      o_mem_write;
    logic      o_branch;
    opcode_t   o_alu_op;
    reg_data_t o_data_a;
    reg_data_t o_data_b;

    reg_data_t   model [`BANK_DEPTH];    // Expected register contents
    logic [31:0] lfsr_state  = 32'd7;
    int          ack_count   = 0;
    int          cycle_count = 0;

    // Instruction word, dest, reg_write, mem_read, mem_write, branch, immediate, alu_op
    decode_vec_t decode_table [N_DECODE] = '{
        '{{6'd0, 5'd1, 5'd2, 5'd3, 5'd0, 6'h20}, 5'd3, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0, 6'h20},
        '{{6'd8, 5'd5, 5'd4, 16'hfff0}, 5'd4, 1'b1, 1'b0, 1'b0, 1'b0, 32'hffff_fff0, 6'd8},
        '{{6'd12, 5'd6, 5'd7, 16'h8001}, 5'd7, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_8001, 6'd12},
        '{{6'd13, 5'd1, 5'd9, 16'hf0f0}, 5'd9, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0000_f0f0, 6'd13},
        '{{6'd35, 5'd2, 5'd10, 16'hfffc}, 5'd10, 1'b1, 1'b1, 1'b0, 1'b0, 32'hffff_fffc, 6'd35},
        '{{6'd43, 5'd3, 5'd11, 16'h0010}, 5'd0, 1'b0, 1'b0, 1'b1, 1'b0, 32'h0000_0010, 6'd43},
        '{{6'd4, 5'd12, 5'd13, 16'h8000}, 5'd0, 1'b0, 1'b0, 1'b0, 1'b1, 32'hffff_8000, 6'd4},
        '{{6'd2, 26'h0000040}, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 6'd2},   // Jump is a no-op
        '{{6'd63, 5'd14, 5'd15, 16'h1234}, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 6'd63}
    };

    decode_stage uut (.*);

    initial begin
        i_clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
    end

    always @(posedge i_clock) begin
        if (o_wb_ack) begin
            ack_count <= ack_count + 1;
        end
    end

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic draw_word(output reg_data_t word);
        word = '0;
        for (int b = 0; b < `NB_DATA; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            word       = {word[`NB_DATA-2:0], lfsr_state[0]};
        end
    endtask

    task automatic wb_access(input logic we, input wb_addr_t adr, input reg_data_t wdata,
                             output reg_data_t rdata);
        int waited;
        int acks_before;
        acks_before = ack_count;
        @(posedge i_clock);
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        i_wb_we  <= we;
        i_wb_adr <= adr;
        i_wb_dat <= wdata;
        waited = 0;
        do begin
            @(negedge i_clock);
            waited++;
        end while (!o_wb_ack && waited < ACK_WAIT);
        assert (o_wb_ack) else begin
            $display("No Wishbone ack at address 0x%0h within %0d cycles", adr, ACK_WAIT);
            abort_run();
        end
        rdata = o_wb_dat;
        @(posedge i_clock);
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
        i_wb_we  <= 1'b0;
        @(negedge i_clock);
        check_value("o_wb_ack", 128'(o_wb_ack), 128'd0);
        check_value("o_wb_ack pulses", 128'(ack_count - acks_before), 128'd1);
    endtask

    task automatic wb_write(input wb_addr_t adr, input reg_data_t data);
        reg_data_t ignored;
        wb_access(1'b1, adr, data, ignored);
    endtask

    task automatic wb_read_check(input wb_addr_t adr, input reg_data_t exp);
        reg_data_t got;
        wb_access(1'b0, adr, '0, got);
        assert (got === exp) else begin
            $display("[FAIL] o_wb_dat at 0x%0h got 0x%0h expected 0x%0h", adr, got, exp);
            abort_run();
        end
    endtask

    function automatic decode_vec_t rtype_vector(input reg_addr_t rs, input reg_addr_t rt);
        decode_vec_t vec;
        vec = '{{6'd0, rs, rt, 5'd3, 5'd0, 6'h20}, 5'd3, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0, 6'h20};
        return vec;
    endfunction

    function automatic logic [127:0] output_snapshot();
        return 128'({o_rs, o_rt, o_dest_reg, o_immediate, o_reg_write, o_mem_read,
                     o_mem_write, o_branch, o_alu_op, o_data_a, o_data_b});
    endfunction

    // Same packing as output_snapshot, built from a table entry and the model
    function automatic logic [127:0] expected_snapshot(input decode_vec_t vec);
        reg_addr_t rs;
        reg_addr_t rt;
        rs = vec.instr[25:21];
        rt = vec.instr[20:16];
        return 128'({rs, rt, vec.dest, vec.imm, vec.reg_write, vec.mem_read,
                     vec.mem_write, vec.branch, vec.alu_op, model[rs], model[rt]});
    endfunction

    // Outputs appear at the edge after the one that samples the word
    task automatic apply_and_check(input decode_vec_t vec);
        reg_addr_t rs;
        reg_addr_t rt;
        rs = vec.instr[25:21];
        rt = vec.instr[20:16];
        @(posedge i_clock);
        i_instruction <= vec.instr;
        @(posedge i_clock);
        @(negedge i_clock);
        check_value("o_rs", 128'(o_rs), 128'(rs));
        check_value("o_rt", 128'(o_rt), 128'(rt));
        check_value("o_dest_reg", 128'(o_dest_reg), 128'(vec.dest));
        check_value("o_reg_write", 128'(o_reg_write), 128'(vec.reg_write));
        check_value("o_mem_read", 128'(o_mem_read), 128'(vec.mem_read));
        check_value("o_mem_write", 128'(o_mem_write), 128'(vec.mem_write));
        check_value("o_branch", 128'(o_branch), 128'(vec.branch));
        check_value("o_immediate", 128'(o_immediate), 128'(vec.imm));
        check_value("o_alu_op", 128'(o_alu_op), 128'(vec.alu_op));
        check_value("o_data_a", 128'(o_data_a), 128'(model[rs]));
        check_value("o_data_b", 128'(o_data_b), 128'(model[rt]));
    endtask

    initial begin
        reg_data_t   value;
        logic [127:0] frozen;
        i_reset       = 1'b1;
        i_instruction = '0;
        i_reg_write   = 1'b0;
        i_write_reg   = '0;
        i_write_data  = '0;
        i_wb_cyc      = 1'b0;
        i_wb_stb      = 1'b0;
        i_wb_we       = 1'b0;
        i_wb_adr      = '0;
        i_wb_dat      = '0;
        for (int r = 0; r < `BANK_DEPTH; r++) begin
            model[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge i_clock);
        i_reset <= 1'b0;
        @(negedge i_clock);

        // Reset state
        check_value("o_wb_ack", 128'(o_wb_ack), 128'd0);
        check_value("decode and data outputs", output_snapshot(), 128'd0);
        wb_read_check(`DBG_CTRL_ADDR, 32'd0);
        wb_read_check(wb_addr_t'(`DBG_REG_BASE + 1), 32'd0);

        // Write-back burst while running, r0 included
        wb_write(`DBG_CTRL_ADDR, 32'd1);
        wb_read_check(`DBG_CTRL_ADDR, 32'd1);
        for (int r = 0; r < `BANK_DEPTH; r++) begin
            draw_word(value);
            @(posedge i_clock);
            i_reg_write  <= 1'b1;
            i_write_reg  <= reg_addr_t'(r);
            i_write_data <= value;
            if (r != 0) begin
                model[r] = value;
            end
        end
        @(posedge i_clock);
        i_reg_write <= 1'b0;
        wb_read_check(wb_addr_t'(`DBG_REG_BASE + 1), 32'd0);   // Window closed while running
        for (int k = 0; k < `BANK_DEPTH / 2; k++) begin
            apply_and_check(rtype_vector(reg_addr_t'(2 * k),
                                         reg_addr_t'(`BANK_DEPTH - 1 - 2 * k)));
        end

        for (int i = 0; i < N_DECODE; i++) begin
            apply_and_check(decode_table[i]);
        end

        // Stall, nothing may move
        wb_write(`DBG_CTRL_ADDR, 32'd0);
        frozen = expected_snapshot(decode_table[N_DECODE - 1]);
        for (int s = 0; s < STALL_CYCLES; s++) begin
            draw_word(value);
            @(posedge i_clock);
            i_instruction <= decode_table[s + 4].instr;
            i_reg_write   <= 1'b1;
            i_write_reg   <= reg_addr_t'(s + 5);
            i_write_data  <= value;
            @(negedge i_clock);
            check_value("decode and data outputs", output_snapshot(), frozen);
        end
        @(posedge i_clock);
        i_reg_write <= 1'b0;
        @(negedge i_clock);
        check_value("decode and data outputs", output_snapshot(), frozen);

        // Halted register dump
        for (int r = 0; r < `BANK_DEPTH; r++) begin
            wb_read_check(wb_addr_t'(`DBG_REG_BASE + r), model[r]);
        end
        wb_read_check(8'h10, 32'd0);
        wb_read_check(wb_addr_t'(`DBG_REG_BASE + `BANK_DEPTH), 32'd0);

        // Resume
        wb_write(`DBG_CTRL_ADDR, 32'd1);
        apply_and_check(decode_table[4]);

        $display("Verification passed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/decode_pkg.sv
register_bank/registers_bank.sv
logic/instruction_decoder.sv
logic/debug_unit.sv
logic/decode_stage.sv
dv/decode_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator, runs it and checks the log.
# Exits non-zero when the build fails or the log lacks the pass line.

rm -f sim.log

verilator --binary --timescale 1ns/1ps -Wno-fatal \
    --top-module decode_stage_tb \
    -f verilog.f \
    --Mdir obj_dir -o decode_stage_sim \
    && ./obj_dir/decode_stage_sim > sim.log 2>&1

[ -f sim.log ] && cat sim.log

grep -q "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
